//--- hw/periph_consts.svh
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// Address map
`define SLOT_LSB       16
`define SLOT_SEG7      2'd0
`define SLOT_UART      2'd1

// Register offsets within a slot
`define REG_SEG7_DATA  16'h0000
`define REG_UART_DATA  16'h0000
`define REG_UART_STAT  16'h0004

// System clocks per half period of the display shift clock
`define SEG_CLK_DIV    4

// System clocks per UART bit
`define BAUD_DIV       16

// AHB transfer types that start a data phase
`define HTRANS_NONSEQ  2'b10
`define HTRANS_SEQ     2'b11

`endif

//--- hw/periph_pkg.sv
`default_nettype none

package periph_pkg;

  // AHB-Lite bus
  typedef logic [31:0] haddr_t;
  typedef logic [31:0] hdata_t;
  typedef logic [1:0]  htrans_t;

  // Decoded peripheral slot, taken from haddr above SLOT_LSB
  typedef logic [1:0]  slot_t;

  // One hex digit of the display word
  typedef logic [3:0]  nibble_t;

  // Segment pattern, active low, {dp, g, f, e, d, c, b, a}
  typedef logic [7:0]  seg_t;

  // Display shifter
  typedef enum logic [1:0] {
    SCAN_IDLE,
    SCAN_SHIFT,
    SCAN_LATCH
  } scan_state_t;

  // UART transmitter, one state per bit kind of an 8N1 frame
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

endpackage

`default_nettype wire

//--- hw/ahb_decoder.sv
`default_nettype none

`include "periph_consts.svh"

module ahb_decoder (
  input  wire                     CLK_FPGA_SYS1,
  input  wire                     rst_n,
  input  wire                     hsel,
  input  wire periph_pkg::haddr_t haddr,
  input  wire periph_pkg::htrans_t htrans,
  output logic                    sel_seg7,
  output logic                    sel_uart,
  input  wire                     hreadyout_seg7,
  input  wire periph_pkg::hdata_t hrdata_seg7,
  input  wire                     hreadyout_uart,
  input  wire periph_pkg::hdata_t hrdata_uart,
  output logic                    hready,
  output periph_pkg::hdata_t      hrdata,
  output logic                    hresp
);

  periph_pkg::slot_t addr_slot;
  periph_pkg::slot_t data_slot;  // Slot owning the current data phase
  logic              addr_act;
  logic              data_act;

  assign addr_slot = haddr[`SLOT_LSB +: $bits(periph_pkg::slot_t)];
  assign addr_act  = hsel && ((htrans == `HTRANS_NONSEQ) || (htrans == `HTRANS_SEQ));

  assign sel_seg7 = hsel && (addr_slot == `SLOT_SEG7);
  assign sel_uart = hsel && (addr_slot == `SLOT_UART);

  // Address phase is accepted only on a ready edge
  always_ff @(posedge CLK_FPGA_SYS1 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      data_act  <= 1'b0;
      data_slot <= `SLOT_SEG7;
    end
    else if (hready)
    begin
      data_act  <= addr_act;
      data_slot <= addr_slot;
    end
  end

  // Response mux, idle and unmapped slots answer at once with zero
  always_comb
  begin
    hready = 1'b1;
    hrdata = '0;
    if (data_act)
    begin
      case (data_slot)
        `SLOT_SEG7:
        begin
          hready = hreadyout_seg7;
          hrdata = hrdata_seg7;
        end
        `SLOT_UART:
        begin
          hready = hreadyout_uart;
          hrdata = hrdata_uart;
        end
        default:
        begin
          hready = 1'b1;  // Null slave
          hrdata = '0;
        end
      endcase
    end
  end

  assign hresp = 1'b0;  // OKAY only

endmodule

`default_nettype wire

//--- hw/ahb_seg7x8.sv
`default_nettype none

`include "periph_consts.svh"

module ahb_seg7x8 (
  input  wire                      CLK_FPGA_SYS1,
  input  wire                      rst_n,
  input  wire                      sel,
  input  wire [15:0]               haddr,
  input  wire periph_pkg::htrans_t htrans,
  input  wire                      hwrite,
  input  wire periph_pkg::hdata_t  hwdata,
  input  wire                      hready_in,
  output logic                     hreadyout,
  output periph_pkg::hdata_t       hrdata,
  output logic                     sh_cp,
  output logic                     st_cp,
  output logic                     ds
);

  localparam int unsigned DIV_W = $clog2(`SEG_CLK_DIV);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SEG_CLK_DIV - 1);

  logic                    wr_pend;
  periph_pkg::hdata_t      disp_word;
  logic [DIV_W-1:0]        div_cnt;
  logic                    tick;
  periph_pkg::scan_state_t state;
  logic [3:0]              bit_cnt;
  logic [2:0]              digit;
  logic [15:0]             shreg;
  logic [15:0]             frame;
  periph_pkg::nibble_t     cur_nib;

  // Common anode pattern table
  function automatic periph_pkg::seg_t seg_lut(input periph_pkg::nibble_t nib);
    case (nib)
      4'h0: seg_lut = 8'hC0;
      4'h1: seg_lut = 8'hF9;
      4'h2: seg_lut = 8'hA4;
      4'h3: seg_lut = 8'hB0;
      4'h4: seg_lut = 8'h99;
      4'h5: seg_lut = 8'h92;
      4'h6: seg_lut = 8'h82;
      4'h7: seg_lut = 8'hF8;
      4'h8: seg_lut = 8'h80;
      4'h9: seg_lut = 8'h90;
      4'hA: seg_lut = 8'h88;
      4'hB: seg_lut = 8'h83;
      4'hC: seg_lut = 8'hC6;
      4'hD: seg_lut = 8'hA1;
      4'hE: seg_lut = 8'h86;
      default: seg_lut = 8'h8E;
    endcase
  endfunction

  assign hreadyout = 1'b1;  // Never stalls
  assign hrdata    = disp_word;

  always_ff @(posedge CLK_FPGA_SYS1 or negedge rst_n)
  begin
    if (!rst_n)
      wr_pend <= 1'b0;
    else if (hready_in)
      wr_pend <= sel && ((htrans == `HTRANS_NONSEQ) || (htrans == `HTRANS_SEQ)) && hwrite
                 && ({haddr[15:2], 2'b00} == `REG_SEG7_DATA);
  end

  always_ff @(posedge CLK_FPGA_SYS1 or negedge rst_n)
  begin
    if (!rst_n)
      disp_word <= '0;
    else if (wr_pend && hready_in)
      disp_word <= hwdata;
  end

  // Segment byte first, then one-hot digit select
  assign cur_nib = disp_word[{digit, 2'b00} +: 4];
  assign frame   = {seg_lut(cur_nib), 8'h01 << digit};
  assign ds      = shreg[15];

  assign tick = (div_cnt == DIV_LAST);

  always_ff @(posedge CLK_FPGA_SYS1 or negedge rst_n)
  begin
    if (!rst_n)
      div_cnt <= '0;
    else if (tick)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 1'b1;
  end

  always_ff @(posedge CLK_FPGA_SYS1 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= periph_pkg::SCAN_IDLE;
      sh_cp   <= 1'b0;
      st_cp   <= 1'b0;
      bit_cnt <= '0;
      digit   <= '0;
      shreg   <= '0;
    end
    else if (tick)
    begin
      case (state)
        periph_pkg::SCAN_IDLE:
        begin
          shreg   <= frame;
          bit_cnt <= '0;
          state   <= periph_pkg::SCAN_SHIFT;
        end
        periph_pkg::SCAN_SHIFT:
        begin
          if (!sh_cp)
            sh_cp <= 1'b1;  // Receiver samples ds here
          else
          begin
            sh_cp <= 1'b0;
            if (bit_cnt == 4'd15)
            begin
              bit_cnt <= '0;
              state   <= periph_pkg::SCAN_LATCH;
            end
            else
            begin
              shreg   <= shreg << 1;
              bit_cnt <= bit_cnt + 4'd1;
            end
          end
        end
        default:
        begin
          // Latch pulse lasts two ticks, one shift period
          if (bit_cnt == 4'd0)
          begin
            st_cp   <= 1'b1;
            bit_cnt <= 4'd1;
          end
          else if (bit_cnt == 4'd1)
            bit_cnt <= 4'd2;
          else
          begin
            st_cp <= 1'b0;
            digit <= digit + 3'd1;
            state <= periph_pkg::SCAN_IDLE;
          end
        end
      endcase
    end
  end

  a_latch_vs_shift: assert property (@(posedge CLK_FPGA_SYS1) disable iff (!rst_n)
    st_cp |-> !sh_cp);

endmodule

`default_nettype wire

//--- hw/ahb_uart_tx.sv
`default_nettype none

`include "periph_consts.svh"

module ahb_uart_tx (
  input  wire                      CLK_FPGA_SYS1,
  input  wire                      rst_n,
  input  wire                      sel,
  input  wire [15:0]               haddr,
  input  wire periph_pkg::htrans_t htrans,
  input  wire                      hwrite,
  input  wire periph_pkg::hdata_t  hwdata,
  input  wire                      hready_in,
  output logic                     hreadyout,
  output periph_pkg::hdata_t       hrdata,
  output logic                     tx
);

  localparam int unsigned BAUD_W = $clog2(`BAUD_DIV);
  localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(`BAUD_DIV - 1);

  logic                  addr_act;
  logic                  wr_pend;  // DATA write in its data phase
  logic                  rd_stat;
  logic                  busy;
  logic                  start;
  periph_pkg::tx_state_t state;
  logic [BAUD_W-1:0]     baud_cnt;
  logic [2:0]            bit_idx;
  logic [7:0]            tx_byte;

  assign addr_act = sel && ((htrans == `HTRANS_NONSEQ) || (htrans == `HTRANS_SEQ));

  always_ff @(posedge CLK_FPGA_SYS1 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_pend <= 1'b0;
      rd_stat <= 1'b0;
    end
    else if (hready_in)
    begin
      wr_pend <= addr_act && hwrite && ({haddr[15:2], 2'b00} == `REG_UART_DATA);
      rd_stat <= addr_act && !hwrite && ({haddr[15:2], 2'b00} == `REG_UART_STAT);
    end
  end

  assign busy      = (state != periph_pkg::TX_IDLE);
  assign hreadyout = !(wr_pend && busy);  // Stretch until the frame is out
  assign start     = wr_pend && !busy;
  assign hrdata    = rd_stat ? {31'd0, busy} : {24'd0, tx_byte};

  always_ff @(posedge CLK_FPGA_SYS1)
  begin
    if (start)
      tx_byte <= hwdata[7:0];
  end

  always_ff @(posedge CLK_FPGA_SYS1 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= periph_pkg::TX_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= 1'b1;
    end
    else if (state == periph_pkg::TX_IDLE)
    begin
      baud_cnt <= '0;
      if (start)
      begin
        state <= periph_pkg::TX_START;
        tx    <= 1'b0;
      end
    end
    else if (baud_cnt != BAUD_LAST)
      baud_cnt <= baud_cnt + 1'b1;
    else
    begin
      baud_cnt <= '0;
      case (state)
        periph_pkg::TX_START:
        begin
          state   <= periph_pkg::TX_DATA;
          bit_idx <= '0;
          tx      <= tx_byte[0];  // LSB first
        end
        periph_pkg::TX_DATA:
        begin
          if (bit_idx == 3'd7)
          begin
            state <= periph_pkg::TX_STOP;
            tx    <= 1'b1;
          end
          else
          begin
            bit_idx <= bit_idx + 3'd1;
            tx      <= tx_byte[bit_idx + 3'd1];
          end
        end
        default:
          state <= periph_pkg::TX_IDLE;  // Stop bit done
      endcase
    end
  end

  // Line must idle high between frames
  a_idle_high: assert property (@(posedge CLK_FPGA_SYS1) disable iff (!rst_n)
    (state == periph_pkg::TX_IDLE) |-> tx);

endmodule

`default_nettype wire

//--- hw/fpga_periph_top.sv
`default_nettype none

module fpga_periph_top (
  input  wire                      CLK_FPGA_SYS1,
  input  wire                      rst_n,
  input  wire                      hsel,
  input  wire periph_pkg::haddr_t  haddr,
  input  wire periph_pkg::htrans_t htrans,
  input  wire                      hwrite,
  input  wire periph_pkg::hdata_t  hwdata,
  output wire                      hready,
  output wire periph_pkg::hdata_t  hrdata,
  output wire                      hresp,
  output wire                      seg7_sh_cp,
  output wire                      seg7_st_cp,
  output wire                      seg7_ds,
  output wire                      uart_tx
);

  logic [1:0]         rst_sync;
  logic               sys_rst_n;
  logic               sel_seg7;
  logic               sel_uart;
  logic               hreadyout_seg7;
  logic               hreadyout_uart;
  periph_pkg::hdata_t hrdata_seg7;
  periph_pkg::hdata_t hrdata_uart;

  // Release of rst_n is synchronized, assertion stays asynchronous
  always_ff @(posedge CLK_FPGA_SYS1 or negedge rst_n)
  begin
    if (!rst_n)
      rst_sync <= 2'b00;
    else
      rst_sync <= {rst_sync[0], 1'b1};
  end

  assign sys_rst_n = rst_sync[1];

  ahb_decoder u_decoder (
    .CLK_FPGA_SYS1  (CLK_FPGA_SYS1),
    .rst_n          (sys_rst_n),
    .hsel           (hsel),
    .haddr          (haddr),
    .htrans         (htrans),
    .sel_seg7       (sel_seg7),
    .sel_uart       (sel_uart),
    .hreadyout_seg7 (hreadyout_seg7),
    .hrdata_seg7    (hrdata_seg7),
    .hreadyout_uart (hreadyout_uart),
    .hrdata_uart    (hrdata_uart),
    .hready         (hready),
    .hrdata         (hrdata),
    .hresp          (hresp)
  );

  // 8 digit display
  ahb_seg7x8 u_seg7 (
    .CLK_FPGA_SYS1 (CLK_FPGA_SYS1),
    .rst_n         (sys_rst_n),
    .sel           (sel_seg7),
    .haddr         (haddr[15:0]),
    .htrans        (htrans),
    .hwrite        (hwrite),
    .hwdata        (hwdata),
    .hready_in     (hready),
    .hreadyout     (hreadyout_seg7),
    .hrdata        (hrdata_seg7),
    .sh_cp         (seg7_sh_cp),
    .st_cp         (seg7_st_cp),
    .ds            (seg7_ds)
  );

  ahb_uart_tx u_uart (
    .CLK_FPGA_SYS1 (CLK_FPGA_SYS1),
    .rst_n         (sys_rst_n),
    .sel           (sel_uart),
    .haddr         (haddr[15:0]),
    .htrans        (htrans),
    .hwrite        (hwrite),
    .hwdata        (hwdata),
    .hready_in     (hready),
    .hreadyout     (hreadyout_uart),
    .hrdata        (hrdata_uart),
    .tx            (uart_tx)
  );

endmodule

`default_nettype wire

//--- tb/tb_fpga_periph.sv
`default_nettype none

`include "periph_consts.svh"

module tb_fpga_periph;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int GOLD_WORDS    = 256;
  localparam int READY_TIMEOUT = 400;  // Longest stall is about one UART frame
  localparam int DISP_TIMEOUT  = 4000;
  localparam int UART_TIMEOUT  = 400;

  logic                CLK_FPGA_SYS1;
  logic                rst_n;
  logic                hsel;
  periph_pkg::haddr_t  haddr;
  periph_pkg::htrans_t htrans;
  logic                hwrite;
  periph_pkg::hdata_t  hwdata;
  logic                hready;
  periph_pkg::hdata_t  hrdata;
  logic                hresp;
  logic                seg7_sh_cp;
  logic                seg7_st_cp;
  logic                seg7_ds;
  logic                uart_tx;

  logic [31:0] gold [GOLD_WORDS];
  logic [7:0]  seg_table [16];
  logic [15:0] frames [8];  // Last latched frame of each digit
  logic [7:0]  uart_bytes [$];
  int          latch_count = 0;
  int          errors = 0;
  int          timeouts = 0;
  int          checks = 0;

  fpga_periph_top uut (
    .CLK_FPGA_SYS1 (CLK_FPGA_SYS1),
    .rst_n         (rst_n),
    .hsel          (hsel),
    .haddr         (haddr),
    .htrans        (htrans),
    .hwrite        (hwrite),
    .hwdata        (hwdata),
    .hready        (hready),
    .hrdata        (hrdata),
    .hresp         (hresp),
    .seg7_sh_cp    (seg7_sh_cp),
    .seg7_st_cp    (seg7_st_cp),
    .seg7_ds       (seg7_ds),
    .uart_tx       (uart_tx)
  );

  initial
  begin
    CLK_FPGA_SYS1 = 1'b0;
    forever #10 CLK_FPGA_SYS1 = ~CLK_FPGA_SYS1;
  end

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    if (got !== want)
    begin
      errors++;
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h at %0t", name, got, want, $time);
    end
  endtask

  task automatic finish_run();
    $display("Errors: %0d  Timeouts: %0d  Checks: %0d", errors, timeouts, checks);
    if (errors == 0 && timeouts == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  endtask

  task automatic timed_out(input string what);
    timeouts++;
    $display("Timeout while waiting for %s at %0t", what, $time);
  endtask

  // hready is sampled mid-cycle, inputs move 2 ns after the edge
  task automatic wait_ready(input string what, output int waits,
                            output periph_pkg::hdata_t rdata, output logic resp);
    logic rdy;
    waits = 0;
    rdy = 1'b0;
    while (!rdy && timeouts == 0)
    begin
      @(negedge CLK_FPGA_SYS1);
      rdy = hready;
      rdata = hrdata;
      resp = hresp;
      @(posedge CLK_FPGA_SYS1);
      #2;
      if (!rdy)
      begin
        waits++;
        if (waits > READY_TIMEOUT)
          timed_out(what);
      end
    end
  endtask

  task automatic ahb_write(input periph_pkg::haddr_t addr, input periph_pkg::hdata_t data,
                           output logic stalled);
    int                 waits;
    periph_pkg::hdata_t rdata;
    logic               resp;
    hsel = 1'b1;
    haddr = addr;
    htrans = `HTRANS_NONSEQ;
    hwrite = 1'b1;
    wait_ready("write address phase", waits, rdata, resp);
    hsel = 1'b0;
    htrans = 2'b00;  // IDLE
    hwrite = 1'b0;
    hwdata = data;
    wait_ready("write data phase", waits, rdata, resp);
    stalled = (waits != 0);
  endtask

  task automatic ahb_read(input periph_pkg::haddr_t addr, output periph_pkg::hdata_t data);
    int                 waits;
    logic               resp;
    hsel = 1'b1;
    haddr = addr;
    htrans = `HTRANS_NONSEQ;
    hwrite = 1'b0;
    wait_ready("read address phase", waits, data, resp);
    hsel = 1'b0;
    htrans = 2'b00;
    wait_ready("read data phase", waits, data, resp);
    compare("hresp", resp, 1'b0);
  endtask

  // Rebuilds each 16 bit frame from ds at rising sh_cp
  task automatic display_monitor();
    logic [15:0] sh;
    logic        prev_sh;
    logic        prev_st;
    sh = '0;
    prev_sh = 1'b0;
    prev_st = 1'b0;
    forever
    begin
      @(negedge CLK_FPGA_SYS1);
      if (seg7_sh_cp && !prev_sh)
        sh = {sh[14:0], seg7_ds};
      if (seg7_st_cp && !prev_st)
      begin
        frames[latch_count % 8] = sh;  // Digits run 0 to 7 from reset
        latch_count++;
      end
      prev_sh = seg7_sh_cp;
      prev_st = seg7_st_cp;
    end
  endtask

  task automatic uart_monitor();
    logic [9:0] bits;
    logic       active;
    int         phase;
    bits = '0;
    active = 1'b0;
    phase = 0;
    forever
    begin
      @(negedge CLK_FPGA_SYS1);
      if (!active)
      begin
        active = (uart_tx == 1'b0);
        phase = 0;
      end
      else
      begin
        phase++;
        if (phase % `BAUD_DIV == `BAUD_DIV / 2 - 1)
          bits[phase / `BAUD_DIV] = uart_tx;  // Middle of bit
        if (phase == 10 * `BAUD_DIV)
        begin
          compare("uart_tx start bit", bits[0], 1'b0);
          compare("uart_tx stop bit", bits[9], 1'b1);
          uart_bytes.push_back(bits[8:1]);
          active = 1'b0;
        end
      end
    end
  endtask

  initial display_monitor();
  initial uart_monitor();

  task automatic check_display(input periph_pkg::hdata_t word);
    int                  first;
    int                  cycles;
    periph_pkg::nibble_t nib;
    first = latch_count;
    cycles = 0;
    while (latch_count < first + 16 && timeouts == 0)  // Second scan is all new data
    begin
      @(posedge CLK_FPGA_SYS1);
      #2;
      cycles++;
      if (cycles > DISP_TIMEOUT)
        timed_out("display latch pulses");
    end
    if (timeouts == 0)
    begin
      for (int k = 0; k < 8; k++)
      begin
        nib = word[4 * k +: 4];
        compare($sformatf("seg7 digit %0d select", k), frames[k][7:0], 8'h01 << k);
        compare($sformatf("seg7 digit %0d segments", k), frames[k][15:8], seg_table[nib]);
      end
    end
  endtask

  task automatic expect_uart(input logic [7:0] want);
    int cycles;
    cycles = 0;
    while (uart_bytes.size() == 0 && timeouts == 0)
    begin
      @(posedge CLK_FPGA_SYS1);
      #2;
      cycles++;
      if (cycles > UART_TIMEOUT)
        timed_out("a UART frame");
    end
    if (uart_bytes.size() != 0)
      compare("uart_tx byte", uart_bytes.pop_front(), want);
  endtask

  initial
  begin
    int                 idx;
    logic               stalled;
    periph_pkg::hdata_t rdata;
    logic [31:0]        op;
    logic [31:0]        addr;
    logic [31:0]        wdata;
    logic [31:0]        want;
    rst_n = 1'b0;
    hsel = 1'b0;
    haddr = '0;
    htrans = 2'b00;
    hwrite = 1'b0;
    hwdata = '0;
    for (idx = 0; idx < GOLD_WORDS; idx++)
      gold[idx] = '0;
    $readmemh("tb/periph_golden.txt", gold);
    repeat (3) @(posedge CLK_FPGA_SYS1);
    #2;
    rst_n = 1'b1;
    repeat (3) @(posedge CLK_FPGA_SYS1);  // Two flop release
    @(negedge CLK_FPGA_SYS1);
    compare("hready", hready, 1'b1);
    compare("uart_tx", uart_tx, 1'b1);
    @(posedge CLK_FPGA_SYS1);
    #2;
    idx = 0;
    while (idx + 3 < GOLD_WORDS && gold[idx] != 32'd0 && timeouts == 0)
    begin
      op = gold[idx];
      addr = gold[idx + 1];
      wdata = gold[idx + 2];
      want = gold[idx + 3];
      case (op)
        32'd1:
        begin
          ahb_write(addr, wdata, stalled);
          compare("hready stall", stalled, want);
        end
        32'd2:
        begin
          ahb_read(addr, rdata);
          compare($sformatf("hrdata at 0x%08h", addr), rdata, want);
        end
        32'd3:
          for (int k = 0; k < 4; k++)
            seg_table[addr[3:0] + k] = want[8 * k +: 8];
        32'd4:
          check_display(want);
        32'd5:
          expect_uart(want[7:0]);
        default:
        begin
          errors++;
          $display("Unknown operation %0d in golden record %0d", op, idx / 4);
        end
      endcase
      idx += 4;
    end
    finish_run();
  end

endmodule

`default_nettype wire

//--- tb/periph_golden.txt
// op addr wdata expect; op 1 write (expect 1 if hready stalls), 2 read, 4 display word,
// 3 segment patterns from nibble addr (low byte first), 5 UART byte, 0 ends the list
3 00000000 00000000 B0A4F9C0
3 00000004 00000000 F8829299
3 00000008 00000000 83889080
3 0000000C 00000000 8E86A1C6
4 00000000 00000000 00000000
2 00020000 00000000 00000000
2 0003FFFC 00000000 00000000
1 00000000 89ABCDEF 00000000
2 00000000 00000000 89ABCDEF
4 00000000 00000000 89ABCDEF
1 00000000 01234567 00000000
2 00000000 00000000 01234567
4 00000000 00000000 01234567
1 00010000 0000005A 00000000
2 00010004 00000000 00000001
5 00000000 00000000 0000005A
2 00010004 00000000 00000000
1 00010000 000000C3 00000000
1 00010000 0000003C 00000001
5 00000000 00000000 000000C3
5 00000000 00000000 0000003C
2 00010004 00000000 00000000
0 00000000 00000000 00000000

//--- build.f
+incdir+hw
hw/periph_pkg.sv
hw/ahb_decoder.sv
hw/ahb_seg7x8.sv
hw/ahb_uart_tx.sv
hw/fpga_periph_top.sv
tb/tb_fpga_periph.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_fpga_periph
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)
